/* hw/zx_pkg.sv */
package zx_pkg;

	////////////////////
	// bus widths
	////////////////////

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;
	// one byte of the port address
	localparam int PORT_W = ADDR_W / 2;

	// paging
	localparam int PAGE_W  = 8;
	localparam int WIN_W   = 2;
	localparam int NUM_WIN = 1 << WIN_W;

	// register field widths
	localparam int MEMCONF_W = 8;
	localparam int TURBO_W   = 2;
	localparam int BORDER_W  = 3;
	localparam int BEEP_BIT  = 4;

	////////////////////
	// port addresses
	////////////////////

	// border/beeper, any high byte
	localparam logic [PORT_W-1:0] PORT_FE_LO      = 8'hFE;
	// extended ports share this low byte
	localparam logic [PORT_W-1:0] PORT_XT_LO      = 8'hAF;
	// page 0, pages 1..3 follow
	localparam logic [PORT_W-1:0] PORT_XTPAGE_HI  = 8'h10;
	localparam logic [PORT_W-1:0] PORT_SYSCONF_HI = 8'h20;
	localparam logic [PORT_W-1:0] PORT_MEMCONF_HI = 8'h21;

	// memconf bits for window 0
	localparam int MEMCONF_W0_RAM = 3;
	localparam int MEMCONF_W0_WE  = 1;

	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_BORDER,
		SEL_XTPAGE,
		SEL_MEMCONF,
		SEL_SYSCONF
	} port_sel_t;

	typedef struct packed {
		logic [NUM_WIN-1:0][PAGE_W-1:0] xt_page;
		logic [MEMCONF_W-1:0]           memconf;
		logic [TURBO_W-1:0]             turbo;
	} zx_cfg_t;

	// page n after reset
	localparam logic [NUM_WIN-1:0][PAGE_W-1:0] XT_PAGE_RST = {
		PAGE_W'(3),
		PAGE_W'(2),
		PAGE_W'(1),
		PAGE_W'(0)
	};

endpackage

/* hw/zport_if.sv */
`timescale 1ns/1ps

interface zport_if;

	// one fclk cycle per finished port write
	logic                     wr_stb;
	// level, held during a read of a readable port
	logic                     rd_act;

	// target of the current cycle
	zx_pkg::port_sel_t        sel;
	// page register number
	logic [zx_pkg::WIN_W-1:0] idx;
	logic [zx_pkg::DATA_W-1:0] wdata;

	modport src (
		output wr_stb,
		output rd_act,
		output sel,
		output idx,
		output wdata
	);

	modport dst (
		input wr_stb,
		input rd_act,
		input sel,
		input idx,
		input wdata
	);

endinterface

/* hw/z80_io_sync.sv */
`timescale 1ns/1ps

module z80_io_sync (
	input  logic                      fclk,
	input  logic                      rst,

	// z80 bus, asynchronous to fclk
	input  logic                      iorq_n,
	input  logic                      rd_n,
	input  logic                      wr_n,
	input  logic [zx_pkg::ADDR_W-1:0] a,
	input  logic [zx_pkg::DATA_W-1:0] d_in,

	zport_if.src                      port
);

	// strobe shift registers, active high
	logic [1:0] iorq_sr;
	logic [1:0] rd_sr;
	logic [1:0] wr_sr;

	logic iorq_s;
	logic iord;
	logic iowr;
	logic iowr_d;

	logic [zx_pkg::ADDR_W-1:0] a_s1;
	logic [zx_pkg::ADDR_W-1:0] a_s2;
	logic [zx_pkg::DATA_W-1:0] d_s1;
	logic [zx_pkg::DATA_W-1:0] d_s2;
	logic [zx_pkg::PORT_W-1:0] a_lo;
	logic [zx_pkg::PORT_W-1:0] a_hi;

	zx_pkg::port_sel_t        sel_nxt;
	logic [zx_pkg::WIN_W-1:0] idx_nxt;
	logic                     rd_ok;

	logic                      wr_stb_q;
	logic                      rd_act_q;
	zx_pkg::port_sel_t         sel_q;
	logic [zx_pkg::WIN_W-1:0]  idx_q;
	logic [zx_pkg::DATA_W-1:0] wdata_q;

	////////////////////
	// synchronizers
	////////////////////

	always_ff @(posedge fclk) begin
		if (rst) begin
			iorq_sr <= '0;
			rd_sr   <= '0;
			wr_sr   <= '0;
		end else begin
			iorq_sr <= {iorq_sr[0], ~iorq_n};
			rd_sr   <= {rd_sr[0], ~rd_n};
			wr_sr   <= {wr_sr[0], ~wr_n};
		end
	end

	// address and data follow the strobes
	always_ff @(posedge fclk) begin
		a_s1 <= a;
		a_s2 <= a_s1;
		d_s1 <= d_in;
		d_s2 <= d_s1;
	end

	assign iorq_s = iorq_sr[1];
	assign iord   = iorq_s & rd_sr[1];
	assign iowr   = iorq_s & wr_sr[1];

	////////////////////
	// port decode
	////////////////////

	assign a_lo = a_s2[zx_pkg::PORT_W-1:0];
	assign a_hi = a_s2[zx_pkg::ADDR_W-1 -: zx_pkg::PORT_W];

	always_comb begin
		sel_nxt = zx_pkg::SEL_NONE;
		idx_nxt = '0;
		if (a_lo == zx_pkg::PORT_FE_LO) begin
			sel_nxt = zx_pkg::SEL_BORDER;
		end else if (a_lo == zx_pkg::PORT_XT_LO) begin
			// #10AF..#13AF
			if (a_hi[zx_pkg::PORT_W-1:zx_pkg::WIN_W] ==
					zx_pkg::PORT_XTPAGE_HI[zx_pkg::PORT_W-1:zx_pkg::WIN_W]) begin
				sel_nxt = zx_pkg::SEL_XTPAGE;
				idx_nxt = a_hi[zx_pkg::WIN_W-1:0];
			end else if (a_hi == zx_pkg::PORT_SYSCONF_HI) begin
				sel_nxt = zx_pkg::SEL_SYSCONF;
			end else if (a_hi == zx_pkg::PORT_MEMCONF_HI) begin
				sel_nxt = zx_pkg::SEL_MEMCONF;
			end
		end
	end

	// border port is write only
	assign rd_ok = (sel_nxt == zx_pkg::SEL_XTPAGE) ||
		(sel_nxt == zx_pkg::SEL_MEMCONF) ||
		(sel_nxt == zx_pkg::SEL_SYSCONF);

	////////////////////
	// port events
	////////////////////

	always_ff @(posedge fclk) begin
		if (rst) begin
			iowr_d   <= 1'b0;
			wr_stb_q <= 1'b0;
			rd_act_q <= 1'b0;
			sel_q    <= zx_pkg::SEL_NONE;
			idx_q    <= '0;
		end else begin
			iowr_d   <= iowr;
			// rising edge of the write cycle
			wr_stb_q <= iowr & ~iowr_d;
			rd_act_q <= iord & rd_ok;
			if (iorq_s) begin
				sel_q <= sel_nxt;
				idx_q <= idx_nxt;
			end
		end
	end

	always_ff @(posedge fclk) begin
		if (iowr)
			wdata_q <= d_s2;
	end

	assign port.wr_stb = wr_stb_q;
	assign port.rd_act = rd_act_q;
	assign port.sel    = sel_q;
	assign port.idx    = idx_q;
	assign port.wdata  = wdata_q;

endmodule

/* hw/port_regs.sv */
`timescale 1ns/1ps

module port_regs (
	input  logic                        fclk,
	input  logic                        rst,

	zport_if.dst                        port,

	// registered configuration
	output zx_pkg::zx_cfg_t             cfg,
	output logic [zx_pkg::BORDER_W-1:0] border,
	output logic                        beep,

	// readback towards the z80
	output logic [zx_pkg::DATA_W-1:0]   d_out,
	output logic                        d_oe
);

	////////////////////
	// register writes
	////////////////////

	always_ff @(posedge fclk) begin
		if (rst) begin
			cfg.xt_page <= zx_pkg::XT_PAGE_RST;
			cfg.memconf <= '0;
			cfg.turbo   <= '0;
			border      <= '0;
			beep        <= 1'b0;
		end else if (port.wr_stb) begin
			case (port.sel)
				zx_pkg::SEL_BORDER: begin
					border <= port.wdata[zx_pkg::BORDER_W-1:0];
					beep   <= port.wdata[zx_pkg::BEEP_BIT];
				end
				zx_pkg::SEL_XTPAGE: begin
					cfg.xt_page[port.idx] <= port.wdata[zx_pkg::PAGE_W-1:0];
				end
				zx_pkg::SEL_MEMCONF: begin
					cfg.memconf <= port.wdata[zx_pkg::MEMCONF_W-1:0];
				end
				zx_pkg::SEL_SYSCONF: begin
					// only turbo is kept
					cfg.turbo <= port.wdata[zx_pkg::TURBO_W-1:0];
				end
				default: begin
				end
			endcase
		end
	end

	////////////////////
	// readback
	////////////////////

	always_comb begin
		d_out = '0;
		case (port.sel)
			zx_pkg::SEL_XTPAGE: begin
				d_out = cfg.xt_page[port.idx];
			end
			zx_pkg::SEL_MEMCONF: begin
				d_out = cfg.memconf;
			end
			zx_pkg::SEL_SYSCONF: begin
				// turbo in low bits, rest reads zero
				d_out = {{(zx_pkg::DATA_W - zx_pkg::TURBO_W){1'b0}}, cfg.turbo};
			end
			default: begin
				d_out = '0;
			end
		endcase
	end

	// front end only raises rd_act for readable ports
	assign d_oe = port.rd_act;

endmodule

/* hw/mem_pager.sv */
`timescale 1ns/1ps

module mem_pager (
	// top two cpu address bits
	input  logic [zx_pkg::WIN_W-1:0]  a_win,
	input  zx_pkg::zx_cfg_t           cfg,

	output logic [zx_pkg::PAGE_W-1:0] page,
	output logic                      romnram,
	output logic                      rw_en
);

	logic win0;
	logic w0_ram;
	logic w0_we;

	// window 0 is the only one with rom
	assign win0   = (a_win == '0);
	assign w0_ram = cfg.memconf[zx_pkg::MEMCONF_W0_RAM];
	assign w0_we  = cfg.memconf[zx_pkg::MEMCONF_W0_WE];

	always_comb begin
		page = cfg.xt_page[a_win];

		// rom in window 0 unless memconf asks for ram
		romnram = win0 && !w0_ram;

		// rom writes need the explicit enable
		rw_en = !(romnram && !w0_we);
	end

endmodule

/* hw/zx_ports_top.sv */
`timescale 1ns/1ps

module zx_ports_top (
	input  logic                        fclk,
	input  logic                        rst,

	// z80 bus
	input  logic                        iorq_n,
	input  logic                        rd_n,
	input  logic                        wr_n,
	input  logic [zx_pkg::ADDR_W-1:0]   a,
	input  logic [zx_pkg::DATA_W-1:0]   d_in,
	output logic [zx_pkg::DATA_W-1:0]   d_out,
	output logic                        d_oe,

	// port outputs
	output logic [zx_pkg::BORDER_W-1:0] border,
	output logic                        beep,
	output logic [zx_pkg::TURBO_W-1:0]  turbo,

	// memory mapping
	output logic [zx_pkg::PAGE_W-1:0]   page,
	output logic                        romnram,
	output logic                        rw_en
);

	zx_pkg::zx_cfg_t cfg;

	zport_if port_bus ();

	////////////////////
	// bus front end
	////////////////////

	z80_io_sync u_io (
		.fclk   (fclk),
		.rst    (rst),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.a      (a),
		.d_in   (d_in),
		.port   (port_bus.src)
	);

	////////////////////
	// port registers
	////////////////////

	port_regs u_regs (
		.fclk   (fclk),
		.rst    (rst),
		.port   (port_bus.dst),
		.cfg    (cfg),
		.border (border),
		.beep   (beep),
		.d_out  (d_out),
		.d_oe   (d_oe)
	);

	////////////////////
	// pager
	////////////////////

	// combinational from the raw cpu address
	mem_pager u_pager (
		.a_win   (a[zx_pkg::ADDR_W-1 -: zx_pkg::WIN_W]),
		.cfg     (cfg),
		.page    (page),
		.romnram (romnram),
		.rw_en   (rw_en)
	);

	assign turbo = cfg.turbo;

endmodule

/* tests/zx_ports_sva.sv */
`timescale 1ns/1ps

module zx_ports_sva (
	input logic                        fclk,
	input logic                        rst,
	input logic [zx_pkg::ADDR_W-1:0]   a,
	input logic [zx_pkg::DATA_W-1:0]   d_out,
	input logic                        d_oe,
	input logic [zx_pkg::BORDER_W-1:0] border,
	input logic                        beep,
	input logic [zx_pkg::TURBO_W-1:0]  turbo,
	input logic [zx_pkg::PAGE_W-1:0]   page,
	input logic                        romnram,
	input logic                        rw_en,
	input zx_pkg::zx_cfg_t             cfg
);

	logic [zx_pkg::WIN_W-1:0] win;
	logic                     w0;

	// number of failed assertions
	int unsigned fail_cnt = 0;

	assign win = a[zx_pkg::ADDR_W-1 -: zx_pkg::WIN_W];
	assign w0  = (win == '0);

	////////////////////
	// reset state
	////////////////////

	reset_state: assert property (@(posedge fclk)
		rst |=> (!d_oe && !beep && border == '0 && turbo == '0))
		else begin
			fail_cnt++;
			$error("outputs not at reset values after reset");
		end

	////////////////////
	// pager rules
	////////////////////

	romnram_rule: assert property (@(posedge fclk) disable iff (rst)
		romnram == (w0 && !cfg.memconf[zx_pkg::MEMCONF_W0_RAM]))
		else begin
			fail_cnt++;
			$error("romnram does not follow window and memconf ram bit");
		end

	rw_en_rule: assert property (@(posedge fclk) disable iff (rst)
		rw_en == !(w0 && !cfg.memconf[zx_pkg::MEMCONF_W0_RAM] &&
			!cfg.memconf[zx_pkg::MEMCONF_W0_WE]))
		else begin
			fail_cnt++;
			$error("rw_en does not follow window and memconf write enable bit");
		end

	// windows 1 to 3 are plain ram
	upper_windows: assert property (@(posedge fclk) disable iff (rst)
		!w0 |-> (!romnram && rw_en))
		else begin
			fail_cnt++;
			$error("upper window mapped as rom or write protected");
		end

	page_rule: assert property (@(posedge fclk) disable iff (rst)
		page == cfg.xt_page[win])
		else begin
			fail_cnt++;
			$error("page differs from page register of the window");
		end

	////////////////////
	// readback
	////////////////////

	oe_port: assert property (@(posedge fclk) disable iff (rst)
		d_oe |-> (a[zx_pkg::PORT_W-1:0] == zx_pkg::PORT_XT_LO))
		else begin
			fail_cnt++;
			$error("d_oe high for a port outside the extended range");
		end

	sysconf_read: assert property (@(posedge fclk) disable iff (rst)
		(d_oe && a[zx_pkg::ADDR_W-1 -: zx_pkg::PORT_W] == zx_pkg::PORT_SYSCONF_HI) |->
		(d_out[zx_pkg::DATA_W-1:zx_pkg::TURBO_W] == '0))
		else begin
			fail_cnt++;
			$error("sysconf read has nonzero upper bits");
		end

endmodule

bind zx_ports_top zx_ports_sva u_sva (
	.fclk    (fclk),
	.rst     (rst),
	.a       (a),
	.d_out   (d_out),
	.d_oe    (d_oe),
	.border  (border),
	.beep    (beep),
	.turbo   (turbo),
	.page    (page),
	.romnram (romnram),
	.rw_en   (rw_en),
	.cfg     (cfg)
);

/* tests/tb_zx_ports.sv */
`timescale 1ns/1ps

module tb_zx_ports;

	localparam int CYC_LIMIT = 2000;
	localparam int HOLD_CLKS = 8;
	localparam int IDLE_CLKS = 4;
	localparam int OE_WAIT   = 3;

	localparam logic [15:0] MEMCONF_PORT = {zx_pkg::PORT_MEMCONF_HI, zx_pkg::PORT_XT_LO};
	localparam logic [15:0] SYSCONF_PORT = {zx_pkg::PORT_SYSCONF_HI, zx_pkg::PORT_XT_LO};
	localparam logic [15:0] UNUSED_PORT  = 16'h30AF;

	logic                        fclk;
	logic                        rst;
	logic                        iorq_n;
	logic                        rd_n;
	logic                        wr_n;
	logic [zx_pkg::ADDR_W-1:0]   a;
	logic [zx_pkg::DATA_W-1:0]   d_in;
	logic [zx_pkg::DATA_W-1:0]   d_out;
	logic                        d_oe;
	logic [zx_pkg::BORDER_W-1:0] border;
	logic                        beep;
	logic [zx_pkg::TURBO_W-1:0]  turbo;
	logic [zx_pkg::PAGE_W-1:0]   page;
	logic                        romnram;
	logic                        rw_en;

	// reference model
	logic [7:0] exp_page [4];
	logic [7:0] exp_memconf;
	logic [1:0] exp_turbo;
	logic [2:0] exp_border;
	logic       exp_beep;

	int seed;
	int cycles = 0;

	zx_ports_top u_zx_ports_top (
		.fclk    (fclk),
		.rst     (rst),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.a       (a),
		.d_in    (d_in),
		.d_out   (d_out),
		.d_oe    (d_oe),
		.border  (border),
		.beep    (beep),
		.turbo   (turbo),
		.page    (page),
		.romnram (romnram),
		.rw_en   (rw_en)
	);

	initial fclk = 1'b0;
	always #50 fclk = ~fclk;

	always @(posedge fclk) begin
		cycles <= cycles + 1;
		if (cycles >= CYC_LIMIT) begin
			$display("Timeout: test did not end within %0d cycles", CYC_LIMIT);
			$display("Finished with errors");
			$fatal(1, "timeout");
		end else if (u_zx_ports_top.u_sva.fail_cnt != 0) begin
			$display("Error at %0t: a bound assertion failed", $time);
			$display("Finished with errors");
			$fatal(1, "assertion failed");
		end
	end

	////////////////////
	// checks
	////////////////////

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, got);
			$display("Finished with errors");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			$display("Error at %0t: %s", $time, what);
			$display("Finished with errors");
			$fatal(1, "bus check failed");
		end
	endtask

	function automatic logic [15:0] page_port(input logic [1:0] n);
		return {zx_pkg::PORT_XTPAGE_HI + {6'b0, n}, zx_pkg::PORT_XT_LO};
	endfunction

	// rom only in window 0 with the ram bit clear
	function automatic logic exp_romnram(input logic [1:0] win);
		return (win == 2'd0) && !exp_memconf[3];
	endfunction

	function automatic logic exp_rw_en(input logic [1:0] win);
		return !(exp_romnram(win) && !exp_memconf[1]);
	endfunction

	////////////////////
	// z80 bus cycles
	////////////////////

	// entered and left on a falling edge
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		a = addr;
		d_in = data;
		iorq_n = 1'b0;
		wr_n = 1'b0;
		repeat (HOLD_CLKS) @(negedge fclk);
		iorq_n = 1'b1;
		wr_n = 1'b1;
		repeat (IDLE_CLKS) @(negedge fclk);
	endtask

	task automatic io_read(input logic [15:0] addr, input logic readable,
			input logic [7:0] exp_data);
		int n;
		a = addr;
		iorq_n = 1'b0;
		rd_n = 1'b0;
		n = 0;
		if (readable) begin
			while (d_oe !== 1'b1 && n < OE_WAIT) begin
				@(negedge fclk);
				n++;
			end
			check_true(d_oe, $sformatf("d_oe did not rise on read of port %h", addr));
			check_val("d_out", d_out, exp_data);
		end
		for (int i = n; i < HOLD_CLKS; i++) begin
			@(negedge fclk);
			if (!readable)
				check_val("d_oe", d_oe, 0);
		end
		iorq_n = 1'b1;
		rd_n = 1'b1;
		n = 0;
		while (d_oe !== 1'b0 && n < OE_WAIT) begin
			@(negedge fclk);
			n++;
		end
		check_true(!d_oe, $sformatf("d_oe stayed high after read of port %h", addr));
		repeat (IDLE_CLKS) @(negedge fclk);
	endtask

	task automatic check_window(input logic [1:0] win);
		a = {win, 14'h0123};
		@(negedge fclk);
		check_val("page", page, exp_page[win]);
		check_val("romnram", romnram, exp_romnram(win));
		check_val("rw_en", rw_en, exp_rw_en(win));
	endtask

	task automatic check_outputs();
		check_val("border", border, exp_border);
		check_val("beep", beep, exp_beep);
		check_val("turbo", turbo, exp_turbo);
	endtask

	task automatic check_readback();
		for (int i = 0; i < 4; i++)
			io_read(page_port(i[1:0]), 1'b1, exp_page[i]);
		io_read(MEMCONF_PORT, 1'b1, exp_memconf);
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial begin
		logic [31:0] rnd;
		logic [7:0]  val;
		seed = 83;
		rst = 1'b1;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		a = '0;
		d_in = '0;
		for (int i = 0; i < 4; i++)
			exp_page[i] = i[7:0];
		exp_memconf = '0;
		exp_turbo = '0;
		exp_border = '0;
		exp_beep = 1'b0;
		repeat (4) @(negedge fclk);
		rst = 1'b0;
		@(negedge fclk);

		// reset state
		check_outputs();
		check_readback();
		for (int w = 0; w < 4; w++)
			check_window(w[1:0]);

		// page registers
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			exp_page[i] = rnd[7:0];
			io_write(page_port(i[1:0]), rnd[7:0]);
		end
		for (int w = 0; w < 4; w++) begin
			check_window(w[1:0]);
			io_read(page_port(w[1:0]), 1'b1, exp_page[w]);
		end

		// every mix of the ram and write enable bits
		for (int m = 0; m < 4; m++) begin
			rnd = $random(seed);
			val = rnd[7:0];
			val[3] = m[1];
			val[1] = m[0];
			io_write(MEMCONF_PORT, val);
			exp_memconf = val;
			io_read(MEMCONF_PORT, 1'b1, exp_memconf);
			for (int w = 0; w < 4; w++)
				check_window(w[1:0]);
		end

		// border and beeper, any high byte
		for (int h = 0; h < 4; h++) begin
			rnd = $random(seed);
			val = rnd[7:0];
			val[4] = h[0];
			io_write({rnd[15:8], zx_pkg::PORT_FE_LO}, val);
			exp_border = val[2:0];
			exp_beep = val[4];
			check_outputs();
			io_read({rnd[15:8], zx_pkg::PORT_FE_LO}, 1'b0, 8'h00);
		end

		// sysconf keeps turbo only
		io_write(SYSCONF_PORT, 8'hFE);
		exp_turbo = 2'b10;
		check_outputs();
		io_read(SYSCONF_PORT, 1'b1, {6'b0, exp_turbo});
		io_write(SYSCONF_PORT, 8'h01);
		exp_turbo = 2'b01;
		check_outputs();
		io_read(SYSCONF_PORT, 1'b1, {6'b0, exp_turbo});

		// unmatched port must leave everything alone
		io_write(UNUSED_PORT, 8'h5A);
		check_outputs();
		io_read(UNUSED_PORT, 1'b0, 8'h00);
		check_readback();
		for (int w = 0; w < 4; w++)
			check_window(w[1:0]);

		if (u_zx_ports_top.u_sva.fail_cnt != 0) begin
			$display("Error at %0t: a bound assertion failed", $time);
			$display("Finished with errors");
			$fatal(1, "assertion failed");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

/* build.f */
hw/zx_pkg.sv
hw/zport_if.sv
hw/z80_io_sync.sv
hw/port_regs.sv
hw/mem_pager.sv
hw/zx_ports_top.sv
tests/zx_ports_sva.sv
tests/tb_zx_ports.sv

/* Makefile */
TOP := tb_zx_ports
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f build.f

# a $fatal in the testbench gives a nonzero exit status
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-Mdir $(OBJ) -f build.f
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
